// ==== include/frame_defs.svh ====
// ----------------------------------------------------------------------
// width and depth macros for the paced frame buffer
// beat, FIFO address, gap length and statistics counter widths
// ----------------------------------------------------------------------

`ifndef FRAME_DEFS_SVH
`define FRAME_DEFS_SVH

// one byte per beat
`define FRAME_DATA_WIDTH 8

// 64-beat frame FIFO
`define FRAME_ADDR_WIDTH 6

// gap length in cycles, up to 15
`define FRAME_GAP_WIDTH 4

// statistics counters
`define FRAME_STAT_WIDTH 16

`endif

// ==== design/frame_pkg.sv ====
// ----------------------------------------------------------------------
// shared types of the paced frame buffer
// beat, pointer, gap and counter vectors plus the sequencer states
// ----------------------------------------------------------------------

`include "frame_defs.svh"

package frame_pkg;

    // one stream beat
    typedef logic [`FRAME_DATA_WIDTH-1:0] data_t;

    // FIFO pointer, msb tells full from empty
    typedef logic [`FRAME_ADDR_WIDTH:0] ptr_t;

    // inter-frame gap length in cycles
    typedef logic [`FRAME_GAP_WIDTH-1:0] gap_t;

    // one saturating event counter
    typedef logic [`FRAME_STAT_WIDTH-1:0] stat_t;

    // tx sequencer FSM
    typedef enum logic [1:0] {
        st_pass,
        st_gap_hold,
        st_gap_release
    } seq_state_t;

endpackage

// ==== design/stream_if.sv ====
// ----------------------------------------------------------------------
// ready/valid byte stream with last flag
// source and sink modports
// ----------------------------------------------------------------------

`timescale 1ns/1ps

interface stream_if;

    frame_pkg::data_t tdata;
    logic             tvalid;
    logic             tready;
    logic             tlast;

    // producer side
    modport src (
        output tdata, tvalid, tlast,
        input  tready
    );

    // consumer side
    modport snk (
        input  tdata, tvalid, tlast,
        output tready
    );

endinterface

// ==== design/frame_fifo.sv ====
// ----------------------------------------------------------------------
// synchronous frame FIFO, only complete good frames become readable
// bad and overflowed frames are rewound, status pulses per frame
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "frame_defs.svh"

module frame_fifo (
    input  logic             output_clk,
    input  logic             output_rst_sync2,
    input  frame_pkg::data_t in_tdata,
    input  logic             in_tvalid,
    input  logic             in_tlast,
    input  logic             in_tuser,
    stream_if.src            m,
    output logic             good_frame,
    output logic             bad_frame,
    output logic             overflow
);

    localparam int ADDR_W = `FRAME_ADDR_WIDTH;
    localparam int DEPTH  = 2 ** `FRAME_ADDR_WIDTH;

    // commit pointer, working pointer, read pointer
    frame_pkg::ptr_t wr_ptr;
    frame_pkg::ptr_t wr_ptr_cur;
    frame_pkg::ptr_t rd_ptr;
    frame_pkg::ptr_t wr_ptr_inc;
    frame_pkg::ptr_t fill_level;

    // rest of the current frame is being thrown away
    logic drop_frame;

    logic full;
    logic full_cur;
    logic empty;
    logic wr_en;
    logic rd_en;

    // tlast is kept in the top bit of each word
    logic [`FRAME_DATA_WIDTH:0] mem [DEPTH];
    logic [`FRAME_DATA_WIDTH:0] data_out;
    logic                       tvalid_reg;

    assign wr_ptr_inc = wr_ptr_cur + 1'b1;

    // working pointer has caught up with the reader
    assign full = (wr_ptr_cur[ADDR_W] != rd_ptr[ADDR_W]) &&
                  (wr_ptr_cur[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    // current frame alone fills the whole memory
    assign full_cur = (wr_ptr_cur[ADDR_W] != wr_ptr[ADDR_W]) &&
                      (wr_ptr_cur[ADDR_W-1:0] == wr_ptr[ADDR_W-1:0]);

    // only committed beats count as readable
    assign empty      = (rd_ptr == wr_ptr);
    assign fill_level = wr_ptr - rd_ptr;

    assign wr_en = in_tvalid && !(full || full_cur || drop_frame);
    assign rd_en = (m.tready || !tvalid_reg) && !empty;

    assign m.tdata  = data_out[`FRAME_DATA_WIDTH-1:0];
    assign m.tlast  = data_out[`FRAME_DATA_WIDTH];
    assign m.tvalid = tvalid_reg;

    // write pointers and per-frame status
    always_ff @(posedge output_clk or posedge output_rst_sync2) begin
        if (output_rst_sync2) begin
            wr_ptr     <= '0;
            wr_ptr_cur <= '0;
            drop_frame <= 1'b0;
            good_frame <= 1'b0;
            bad_frame  <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            // pulses last one cycle
            good_frame <= 1'b0;
            bad_frame  <= 1'b0;
            overflow   <= 1'b0;
            if (in_tvalid) begin
                if (full || full_cur || drop_frame) begin
                    // no room, discard until the last beat
                    drop_frame <= 1'b1;
                    if (in_tlast) begin
                        wr_ptr_cur <= wr_ptr;
                        drop_frame <= 1'b0;
                        overflow   <= 1'b1;
                    end
                end else begin
                    wr_ptr_cur <= wr_ptr_inc;
                    if (in_tlast) begin
                        if (in_tuser) begin
                            // error on last beat, forget the frame
                            wr_ptr_cur <= wr_ptr;
                            bad_frame  <= 1'b1;
                        end else begin
                            // frame becomes visible to the read side
                            wr_ptr     <= wr_ptr_inc;
                            good_frame <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    // storage
    always_ff @(posedge output_clk) begin
        if (wr_en) begin
            mem[wr_ptr_cur[ADDR_W-1:0]] <= {in_tlast, in_tdata};
        end
    end

    // read pointer and output valid
    always_ff @(posedge output_clk or posedge output_rst_sync2) begin
        if (output_rst_sync2) begin
            rd_ptr     <= '0;
            tvalid_reg <= 1'b0;
        end else begin
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // refill the output register when it is free
            if (m.tready || !tvalid_reg) begin
                tvalid_reg <= !empty;
            end
        end
    end

    // output data register
    always_ff @(posedge output_clk) begin
        if (rd_en) begin
            data_out <= mem[rd_ptr[ADDR_W-1:0]];
        end
    end

    // reader never overtakes the commit pointer
    assert property (@(posedge output_clk) disable iff (output_rst_sync2)
        fill_level <= DEPTH);

endmodule

// ==== design/gap_timer.sv ====
// ----------------------------------------------------------------------
// inter-frame gap timer, four-phase req/ack
// counts gap_len down after req rises, ack held until req falls
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module gap_timer (
    input  logic            output_clk,
    input  logic            output_rst_sync2,
    input  logic            gap_req,
    input  frame_pkg::gap_t gap_len,
    output logic            gap_ack
);

    frame_pkg::gap_t cnt;

    // req from the previous cycle, for edge detection
    logic req_q;

    // count in progress
    logic running;

    always_ff @(posedge output_clk or posedge output_rst_sync2) begin
        if (output_rst_sync2) begin
            req_q   <= 1'b0;
            running <= 1'b0;
            cnt     <= '0;
            gap_ack <= 1'b0;
        end else begin
            req_q <= gap_req;
            if (!gap_req) begin
                // phase 4, drop ack after req is gone
                gap_ack <= 1'b0;
                running <= 1'b0;
            end else if (!req_q) begin
                // phase 1, latch the length
                cnt     <= gap_len;
                running <= 1'b1;
            end else if (running) begin
                if (cnt == '0) begin
                    // phase 2, gap spent
                    gap_ack <= 1'b1;
                    running <= 1'b0;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

    // ack never shows up while req is low
    assert property (@(posedge output_clk) disable iff (output_rst_sync2)
        $rose(gap_ack) |-> gap_req);

    // a new request only once ack has gone low
    assert property (@(posedge output_clk) disable iff (output_rst_sync2)
        $rose(gap_req) |-> !gap_ack);

endmodule

// ==== design/tx_sequencer.sv ====
// ----------------------------------------------------------------------
// output FSM, passes FIFO frames through to the output port
// blocks the stream for a gap after each last beat via req/ack
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tx_sequencer (
    input  logic             output_clk,
    input  logic             output_rst_sync2,
    stream_if.snk            s,
    output frame_pkg::data_t out_tdata,
    output logic             out_tvalid,
    output logic             out_tlast,
    input  logic             out_tready,
    output logic             gap_req,
    input  logic             gap_ack
);

    frame_pkg::seq_state_t state;
    frame_pkg::seq_state_t state_next;

    // stream open only while passing
    logic pass;

    // last beat leaves on this cycle
    logic last_accept;

    assign pass        = (state == frame_pkg::st_pass);
    assign last_accept = pass && s.tvalid && s.tlast && out_tready;

    // combinational path through the FSM
    assign out_tdata  = s.tdata;
    assign out_tlast  = s.tlast;
    assign out_tvalid = pass && s.tvalid;
    assign s.tready   = pass && out_tready;

    // request held for the whole hold phase
    assign gap_req = (state == frame_pkg::st_gap_hold);

    always_comb begin
        state_next = state;
        case (state)
            frame_pkg::st_pass: begin
                if (last_accept) begin
                    state_next = frame_pkg::st_gap_hold;
                end
            end
            frame_pkg::st_gap_hold: begin
                // wait for the timer to finish
                if (gap_ack) begin
                    state_next = frame_pkg::st_gap_release;
                end
            end
            frame_pkg::st_gap_release: begin
                // req is low, wait for ack to drop
                if (!gap_ack) begin
                    state_next = frame_pkg::st_pass;
                end
            end
            default: begin
                state_next = frame_pkg::st_pass;
            end
        endcase
    end

    always_ff @(posedge output_clk or posedge output_rst_sync2) begin
        if (output_rst_sync2) begin
            state <= frame_pkg::st_pass;
        end else begin
            state <= state_next;
        end
    end

    // a presented beat stays, unchanged, until the port takes it
    assert property (@(posedge output_clk) disable iff (output_rst_sync2)
        out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata)
            && $stable(out_tlast));

endmodule

// ==== design/frame_stats.sv ====
// ----------------------------------------------------------------------
// saturating frame counters
// good, bad and overflowed frames from the FIFO status pulses
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module frame_stats (
    input  logic             output_clk,
    input  logic             output_rst_sync2,
    input  logic             good_frame,
    input  logic             bad_frame,
    input  logic             overflow,
    output frame_pkg::stat_t good_count,
    output frame_pkg::stat_t bad_count,
    output frame_pkg::stat_t overflow_count
);

    // step by one on an event, stick at all ones
    function automatic frame_pkg::stat_t sat_inc(input frame_pkg::stat_t cnt,
                                                 input logic ev);
        frame_pkg::stat_t res;
        res = cnt;
        if (ev && (cnt != '1)) begin
            res = cnt + 1'b1;
        end
        return res;
    endfunction

    always_ff @(posedge output_clk or posedge output_rst_sync2) begin
        if (output_rst_sync2) begin
            good_count     <= '0;
            bad_count      <= '0;
            overflow_count <= '0;
        end else begin
            good_count     <= sat_inc(good_count, good_frame);
            bad_count      <= sat_inc(bad_count, bad_frame);
            overflow_count <= sat_inc(overflow_count, overflow);
        end
    end

    // a frame ends in exactly one way
    assert property (@(posedge output_clk) disable iff (output_rst_sync2)
        $onehot0({good_frame, bad_frame, overflow}));

endmodule

// ==== design/frame_pacer_top.sv ====
// ----------------------------------------------------------------------
// paced frame buffer top level
// frame FIFO, output sequencer, gap timer and statistics
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module frame_pacer_top (
    input  logic             output_clk,
    input  logic             output_rst_sync2,
    // input push stream, always accepted
    input  frame_pkg::data_t in_tdata,
    input  logic             in_tvalid,
    input  logic             in_tlast,
    input  logic             in_tuser,
    // paced output stream
    output frame_pkg::data_t out_tdata,
    output logic             out_tvalid,
    input  logic             out_tready,
    output logic             out_tlast,
    // idle cycles after each frame
    input  frame_pkg::gap_t  gap_len,
    // statistics
    output frame_pkg::stat_t good_count,
    output frame_pkg::stat_t bad_count,
    output frame_pkg::stat_t overflow_count
);

    // FIFO to sequencer
    stream_if fifo_s ();

    // gap handshake
    logic gap_req;
    logic gap_ack;

    // per-frame status pulses
    logic good_frame;
    logic bad_frame;
    logic overflow;

    frame_fifo u_fifo (
        .output_clk       (output_clk),
        .output_rst_sync2 (output_rst_sync2),
        .in_tdata         (in_tdata),
        .in_tvalid        (in_tvalid),
        .in_tlast         (in_tlast),
        .in_tuser         (in_tuser),
        .m                (fifo_s.src),
        .good_frame       (good_frame),
        .bad_frame        (bad_frame),
        .overflow         (overflow)
    );

    tx_sequencer u_seq (
        .output_clk       (output_clk),
        .output_rst_sync2 (output_rst_sync2),
        .s                (fifo_s.snk),
        .out_tdata        (out_tdata),
        .out_tvalid       (out_tvalid),
        .out_tlast        (out_tlast),
        .out_tready       (out_tready),
        .gap_req          (gap_req),
        .gap_ack          (gap_ack)
    );

    gap_timer u_gap (
        .output_clk       (output_clk),
        .output_rst_sync2 (output_rst_sync2),
        .gap_req          (gap_req),
        .gap_len          (gap_len),
        .gap_ack          (gap_ack)
    );

    frame_stats u_stats (
        .output_clk       (output_clk),
        .output_rst_sync2 (output_rst_sync2),
        .good_frame       (good_frame),
        .bad_frame        (bad_frame),
        .overflow         (overflow),
        .good_count       (good_count),
        .bad_count        (bad_count),
        .overflow_count   (overflow_count)
    );

endmodule

// ==== dv/frame_pacer_tb.sv ====
// ----------------------------------------------------------------------
// directed testbench for the paced frame buffer
// model queue of expected beats, output monitor, gap check, watchdog
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "frame_defs.svh"

module frame_pacer_tb;

    localparam int DEPTH       = 2 ** `FRAME_ADDR_WIDTH;
    localparam int TOTAL_BEATS = 360;
    // gap_len 15 plus the handshake round trip
    localparam int WORST_GAP   = 21;
    localparam int TIMEOUT_CYC = TOTAL_BEATS * WORST_GAP * 4;
    localparam int DRAIN_LIMIT = 4000;

    logic             output_clk;
    logic             output_rst_sync2;
    frame_pkg::data_t in_tdata;
    logic             in_tvalid;
    logic             in_tlast;
    logic             in_tuser;
    frame_pkg::data_t out_tdata;
    logic             out_tvalid;
    logic             out_tready;
    logic             out_tlast;
    frame_pkg::gap_t  gap_len;
    frame_pkg::stat_t good_count;
    frame_pkg::stat_t bad_count;
    frame_pkg::stat_t overflow_count;

    // expected beats, tlast in the top bit
    logic [`FRAME_DATA_WIDTH:0] exp_q [$];
    int exp_good = 0;
    int exp_bad  = 0;
    int exp_ovf  = 0;
    int errors   = 0;
    int cyc      = 0;
    // 0 always ready, 1 held low, 2 random
    int ready_mode = 0;
    // end of the last frame seen at the output
    int last_end_cyc = 0;
    bit gap_armed    = 1'b0;
    int gap_at_end   = 0;
    int gap_checks   = 0;

    frame_pacer_top DUT (
        .output_clk       (output_clk),
        .output_rst_sync2 (output_rst_sync2),
        .in_tdata         (in_tdata),
        .in_tvalid        (in_tvalid),
        .in_tlast         (in_tlast),
        .in_tuser         (in_tuser),
        .out_tdata        (out_tdata),
        .out_tvalid       (out_tvalid),
        .out_tready       (out_tready),
        .out_tlast        (out_tlast),
        .gap_len          (gap_len),
        .good_count       (good_count),
        .bad_count        (bad_count),
        .overflow_count   (overflow_count)
    );

    always #4 output_clk = ~output_clk;

    task automatic abort_run(input string reason);
        errors++;
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string what, input int got, input int expected);
        if (got != expected) begin
            abort_run($sformatf("Error at %0d ns: %s is %0d, expected %0d",
                                $time, what, got, expected));
        end
    endtask

    // output back-pressure pattern
    always @(posedge output_clk) begin
        case (ready_mode)
            0:       out_tready <= 1'b1;
            1:       out_tready <= 1'b0;
            default: out_tready <= ($urandom % 4) != 0;
        endcase
    end

    // monitor, every accepted beat against the model head
    always @(posedge output_clk) begin
        logic [`FRAME_DATA_WIDTH:0] head;
        int idle;
        if (!output_rst_sync2) begin
            if (out_tvalid && gap_armed) begin
                idle = cyc - last_end_cyc - 1;
                check_value($sformatf("%0d idle cycles at gap_len %0d, at least gap_len+1",
                                      idle, gap_at_end), idle >= gap_at_end + 1, 1);
                gap_armed = 1'b0;
                gap_checks++;
            end
            if (out_tvalid && out_tready) begin
                if (exp_q.size() == 0) begin
                    abort_run("the output produced a beat while no frame was expected");
                end else begin
                    head = exp_q.pop_front();
                    check_value("out_tdata", out_tdata, head[`FRAME_DATA_WIDTH-1:0]);
                    check_value("out_tlast", out_tlast, head[`FRAME_DATA_WIDTH]);
                    if (out_tlast) begin
                        last_end_cyc = cyc;
                        gap_armed    = 1'b1;
                        gap_at_end   = gap_len;
                    end
                end
            end
        end
        cyc = cyc + 1;
    end

    // drives one frame, the model keeps it only if good and it fits
    task automatic send_frame(input int len, input bit bad);
        frame_pkg::data_t d;
        bit fits;
        fits = len <= DEPTH - exp_q.size();
        if (!fits) begin
            exp_ovf++;
        end else if (bad) begin
            exp_bad++;
        end else begin
            exp_good++;
        end
        for (int i = 0; i < len; i++) begin
            d = $urandom;
            if (fits && !bad) begin
                exp_q.push_back({i == len - 1, d});
            end
            @(posedge output_clk);
            in_tdata  <= d;
            in_tvalid <= 1'b1;
            in_tlast  <= (i == len - 1);
            in_tuser  <= bad && (i == len - 1);
        end
        @(posedge output_clk);
        in_tvalid <= 1'b0;
        in_tlast  <= 1'b0;
        in_tuser  <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(posedge output_clk);
            n++;
            if (n > DRAIN_LIMIT) begin
                abort_run("expected frames did not reach the output in time");
            end
        end
        // status pulses still on their way to the counters
        repeat (4) @(posedge output_clk);
    endtask

    task automatic check_counts();
        check_value("good_count", good_count, exp_good);
        check_value("bad_count", bad_count, exp_bad);
        check_value("overflow_count", overflow_count, exp_ovf);
    endtask

    task automatic reset_state_is_idle();
        check_value("out_tvalid after reset", out_tvalid, 0);
        check_counts();
    endtask

    task automatic good_frames_in_order();
        int lens [5] = '{1, 2, 7, 16, 23};
        foreach (lens[i]) begin
            send_frame(lens[i], 1'b0);
        end
        wait_drain();
        check_counts();
    endtask

    task automatic bad_frame_dropped();
        send_frame(5, 1'b0);
        send_frame(9, 1'b1);
        send_frame(6, 1'b0);
        wait_drain();
        check_counts();
    endtask

    task automatic overflow_frames_dropped();
        ready_mode = 1;
        repeat (2) @(posedge output_clk);
        send_frame(10, 1'b0);
        send_frame(10, 1'b0);
        repeat (4) @(posedge output_clk);
        // longer than the whole buffer, then longer than what is left
        send_frame(70, 1'b0);
        send_frame(50, 1'b0);
        repeat (4) @(posedge output_clk);
        // first stored beat waits at the port
        check_value("out_tvalid under back-pressure", out_tvalid, 1);
        check_counts();
        ready_mode = 0;
        wait_drain();
        check_counts();
    endtask

    task automatic random_ready_matches();
        ready_mode = 2;
        for (int i = 0; i < 8; i++) begin
            // keep well clear of the depth
            while (exp_q.size() > 16) begin
                @(posedge output_clk);
            end
            send_frame(1 + ($urandom % 16), 1'b0);
        end
        wait_drain();
        ready_mode = 0;
        check_counts();
    endtask

    task automatic gap_after_each_frame();
        int gaps [3] = '{0, 3, 15};
        int start;
        foreach (gaps[i]) begin
            @(posedge output_clk);
            gap_len <= frame_pkg::gap_t'(gaps[i]);
            @(posedge output_clk);
            start = gap_checks;
            // second frame waits while the gap runs
            send_frame(4, 1'b0);
            send_frame(3, 1'b0);
            wait_drain();
            check_value($sformatf("gap measured at gap_len %0d", gaps[i]),
                        gap_checks > start, 1);
        end
        check_counts();
    endtask

    initial begin
        void'($urandom(32'hafc9_2c00));
        output_clk       = 1'b0;
        output_rst_sync2 = 1'b1;
        in_tdata         = '0;
        in_tvalid        = 1'b0;
        in_tlast         = 1'b0;
        in_tuser         = 1'b0;
        out_tready       = 1'b0;
        gap_len          = 4'd2;
        repeat (16) @(posedge output_clk);
        output_rst_sync2 <= 1'b0;
        @(posedge output_clk);
        reset_state_is_idle();
        good_frames_in_order();
        bad_frame_dropped();
        overflow_frames_dropped();
        random_ready_matches();
        gap_after_each_frame();
        if (errors == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            abort_run("errors were recorded during the run");
        end
    end

    // watchdog
    initial begin
        repeat (TIMEOUT_CYC) @(posedge output_clk);
        abort_run($sformatf("watchdog expired after %0d cycles, the tests did not finish",
                            TIMEOUT_CYC));
    end

endmodule

// ==== vlog.f ====
+incdir+include
design/frame_pkg.sv
design/stream_if.sv
design/frame_fifo.sv
design/gap_timer.sv
design/tx_sequencer.sv
design/frame_stats.sv
design/frame_pacer_top.sv
dv/frame_pacer_tb.sv

// ==== Bender.yml ====
package:
  name: frame_pacer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/frame_pkg.sv
      - design/stream_if.sv
      - design/frame_fifo.sv
      - design/gap_timer.sv
      - design/tx_sequencer.sv
      - design/frame_stats.sv
      - design/frame_pacer_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/frame_pacer_tb.sv
